// File: src/core_pkg.sv
/*
 * RV32I core package
 * Widths, register ranges and the decode enums shared by the pipeline
 */
`default_nettype none

package core_pkg;

  localparam int XLEN       = 32;
  localparam int ADDR_BITS  = 12;
  localparam int IMEM_WORDS = 1024;
  localparam int REG_BITS   = 5;

  // Writes to a0..a7 are reported on the peripheral port
  localparam int PERIPH_REG_FIRST = 10;
  localparam int PERIPH_REG_LAST  = 17;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    // Operand B straight through, for LUI
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {NPC_SEQ, NPC_BRANCH, NPC_JAL, NPC_JALR} next_pc_e;

  typedef enum logic {OPA_RS1, OPA_PC} opa_sel_e;

  typedef enum logic [1:0] {FWD_NONE, FWD_FROM_EX, FWD_FROM_WB} fwd_sel_e;

endpackage

`default_nettype wire

// File: src/id_ex_if.sv
/*
 * ID/EX bundle
 * One decoded instruction passed from decode to execute
 */
`timescale 1ns/1ps
`default_nettype none

interface id_ex_if;

  logic                               valid;
  logic [core_pkg::ADDR_BITS-1:0]     pc;
  logic [core_pkg::XLEN-1:0]          rs1_data;
  logic [core_pkg::XLEN-1:0]          rs2_data;
  logic [core_pkg::XLEN-1:0]          imm;
  logic [core_pkg::REG_BITS-1:0]      rd;
  logic                               reg_write;
  core_pkg::alu_op_e                  alu_op;
  core_pkg::opa_sel_e                 opa_sel;
  logic                               opb_imm;
  core_pkg::next_pc_e                 next_pc;
  logic [2:0]                         funct3;

  modport decode (output valid, pc, rs1_data, rs2_data, imm, rd, reg_write,
                  alu_op, opa_sel, opb_imm, next_pc, funct3);
  modport execute (input valid, pc, rs1_data, rs2_data, imm, rd, reg_write,
                   alu_op, opa_sel, opb_imm, next_pc, funct3);

endinterface

`default_nettype wire

// File: src/instr_mem.sv
/*
 * Instruction memory
 * Word array loaded through the ISP port, read combinationally by fetch
 */
`timescale 1ns/1ps
`default_nettype none

module instr_mem (
  input  logic                           clock,
  input  logic                           i_isp_write,
  input  logic [core_pkg::ADDR_BITS-1:0] i_isp_address,
  input  logic [core_pkg::XLEN-1:0]      i_isp_data,
  input  logic [core_pkg::ADDR_BITS-1:0] i_fetch_address,
  output logic [core_pkg::XLEN-1:0]      o_fetch_data
);

  logic [core_pkg::XLEN-1:0] mem [core_pkg::IMEM_WORDS];

  // Word index taken from the upper byte address bits
  always_ff @(posedge clock) begin
    if (i_isp_write) begin
      mem[i_isp_address[core_pkg::ADDR_BITS-1:2]] <= i_isp_data;
    end
  end

  assign o_fetch_data = mem[i_fetch_address[core_pkg::ADDR_BITS-1:2]];

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
/*
 * Fetch stage
 * PC with start gating and redirect, feeding the IF/ID register
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic                           clock,
  input  logic                           i_rst_n,
  input  logic                           i_start,
  input  logic [core_pkg::ADDR_BITS-1:0] i_prog_address,
  input  logic                           i_redirect,
  input  logic [core_pkg::ADDR_BITS-1:0] i_redirect_target,
  output logic [core_pkg::ADDR_BITS-1:0] o_fetch_address,
  input  logic [core_pkg::XLEN-1:0]      i_fetch_data,
  output logic                           o_if_valid,
  output logic [core_pkg::XLEN-1:0]      o_if_instr,
  output logic [core_pkg::ADDR_BITS-1:0] o_if_pc
);

  logic                           running;
  logic [core_pkg::ADDR_BITS-1:0] pc;

  assign o_fetch_address = pc;

  always_ff @(posedge clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      running    <= 1'b0;
      pc         <= '0;
      o_if_valid <= 1'b0;
    end else begin
      o_if_valid <= 1'b0;
      if (i_start) begin
        running <= 1'b1;
        pc      <= i_prog_address;
      end else if (i_redirect) begin
        // Instruction fetched this cycle is on the wrong path
        pc <= i_redirect_target;
      end else if (running) begin
        pc         <= pc + 4;
        o_if_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    o_if_instr <= i_fetch_data;
    o_if_pc    <= pc;
  end

  // Start address and jump targets must both land on words
  pc_aligned: assert property (@(posedge clock) disable iff (!i_rst_n) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: src/control_unit.sv
/*
 * Control unit
 * Opcode decode, bypass selection and pipeline flush
 */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  logic                          clock,
  input  logic                          i_if_valid,
  input  logic [core_pkg::XLEN-1:0]     i_instr,
  input  logic [core_pkg::REG_BITS-1:0] i_ex_rd,
  input  logic                          i_ex_reg_write,
  input  logic [core_pkg::REG_BITS-1:0] i_wb_rd,
  input  logic                          i_wb_write,
  input  logic                          i_redirect,
  output core_pkg::alu_op_e             o_alu_op,
  output core_pkg::opa_sel_e            o_opa_sel,
  output logic                          o_opb_imm,
  output core_pkg::next_pc_e            o_next_pc,
  output logic                          o_reg_write,
  output core_pkg::fwd_sel_e            o_fwd_rs1,
  output core_pkg::fwd_sel_e            o_fwd_rs2,
  output logic                          o_flush
);

  function automatic core_pkg::alu_op_e alu_from_funct(input logic [2:0] f3,
                                                       input logic f7b5,
                                                       input logic is_reg);
    case (f3)
      3'b000:  return (is_reg && f7b5) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      3'b001:  return core_pkg::ALU_SLL;
      3'b010:  return core_pkg::ALU_SLT;
      3'b011:  return core_pkg::ALU_SLTU;
      3'b100:  return core_pkg::ALU_XOR;
      3'b101:  return f7b5 ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      3'b110:  return core_pkg::ALU_OR;
      default: return core_pkg::ALU_AND;
    endcase
  endfunction

  // Youngest in-flight writer wins and x0 is never forwarded
  function automatic core_pkg::fwd_sel_e fwd_for(input logic [core_pkg::REG_BITS-1:0] rs);
    if (rs == '0) return core_pkg::FWD_NONE;
    if (i_ex_reg_write && i_ex_rd == rs) return core_pkg::FWD_FROM_EX;
    if (i_wb_write && i_wb_rd == rs) return core_pkg::FWD_FROM_WB;
    return core_pkg::FWD_NONE;
  endfunction

  always_comb begin
    o_alu_op    = core_pkg::ALU_ADD;
    o_opa_sel   = core_pkg::OPA_RS1;
    o_opb_imm   = 1'b0;
    o_next_pc   = core_pkg::NPC_SEQ;
    o_reg_write = 1'b0;
    if (i_if_valid) begin
      case (i_instr[6:0])
        core_pkg::OPC_OP: begin
          o_alu_op    = alu_from_funct(i_instr[14:12], i_instr[30], 1'b1);
          o_reg_write = 1'b1;
        end
        core_pkg::OPC_OP_IMM: begin
          o_alu_op    = alu_from_funct(i_instr[14:12], i_instr[30], 1'b0);
          o_opb_imm   = 1'b1;
          o_reg_write = 1'b1;
        end
        core_pkg::OPC_LUI: begin
          o_alu_op    = core_pkg::ALU_PASS_B;
          o_opb_imm   = 1'b1;
          o_reg_write = 1'b1;
        end
        core_pkg::OPC_AUIPC: begin
          o_opa_sel   = core_pkg::OPA_PC;
          o_opb_imm   = 1'b1;
          o_reg_write = 1'b1;
        end
        core_pkg::OPC_JAL: begin
          o_next_pc   = core_pkg::NPC_JAL;
          o_reg_write = 1'b1;
        end
        core_pkg::OPC_JALR: begin
          o_opb_imm   = 1'b1;
          o_next_pc   = core_pkg::NPC_JALR;
          o_reg_write = 1'b1;
        end
        core_pkg::OPC_BRANCH: o_next_pc = core_pkg::NPC_BRANCH;
        default: ;
      endcase
    end
  end

  always_comb begin
    o_fwd_rs1 = fwd_for(i_instr[19:15]);
    o_fwd_rs2 = fwd_for(i_instr[24:20]);
  end

  assign o_flush = i_redirect;

  // The flushed slot cannot redirect again on the following cycle
  flush_on_redirect: assert property (@(posedge clock) o_flush |=> !i_redirect);

endmodule

`default_nettype wire

// File: src/decode_unit.sv
/*
 * Decode stage
 * Register file, immediates, operand bypass and the ID/EX register
 */
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
  input  logic                           clock,
  input  logic                           i_rst_n,
  input  logic                           i_if_valid,
  input  logic [core_pkg::XLEN-1:0]      i_if_instr,
  input  logic [core_pkg::ADDR_BITS-1:0] i_if_pc,
  input  core_pkg::alu_op_e              i_alu_op,
  input  core_pkg::opa_sel_e             i_opa_sel,
  input  logic                           i_opb_imm,
  input  core_pkg::next_pc_e             i_next_pc,
  input  logic                           i_reg_write,
  input  core_pkg::fwd_sel_e             i_fwd_rs1,
  input  core_pkg::fwd_sel_e             i_fwd_rs2,
  input  logic                           i_flush,
  input  logic [core_pkg::XLEN-1:0]      i_ex_result,
  input  logic                           i_wb_write,
  input  logic [core_pkg::REG_BITS-1:0]  i_wb_rd,
  input  logic [core_pkg::XLEN-1:0]      i_wb_data,
  id_ex_if.decode                        o_id_ex
);

  logic [core_pkg::XLEN-1:0]     regs [2**core_pkg::REG_BITS];
  logic [core_pkg::REG_BITS-1:0] rs1;
  logic [core_pkg::REG_BITS-1:0] rs2;
  logic [core_pkg::XLEN-1:0]     imm;

  function automatic logic [core_pkg::XLEN-1:0] bypass(input core_pkg::fwd_sel_e sel,
                                                       input logic [core_pkg::XLEN-1:0] rf);
    case (sel)
      core_pkg::FWD_FROM_EX: return i_ex_result;
      core_pkg::FWD_FROM_WB: return i_wb_data;
      default:               return rf;
    endcase
  endfunction

  assign rs1 = i_if_instr[19:15];
  assign rs2 = i_if_instr[24:20];

  always_ff @(posedge clock) begin
    if (i_wb_write) begin
      regs[i_wb_rd] <= i_wb_data;
    end
  end

  always_comb begin
    case (i_if_instr[6:0])
      core_pkg::OPC_LUI, core_pkg::OPC_AUIPC: imm = {i_if_instr[31:12], 12'b0};
      core_pkg::OPC_BRANCH: imm = {{20{i_if_instr[31]}}, i_if_instr[7],
                                   i_if_instr[30:25], i_if_instr[11:8], 1'b0};
      core_pkg::OPC_JAL: imm = {{12{i_if_instr[31]}}, i_if_instr[19:12],
                                i_if_instr[20], i_if_instr[30:21], 1'b0};
      // I-type for OP_IMM and JALR
      default: imm = {{20{i_if_instr[31]}}, i_if_instr[31:20]};
    endcase
  end

  always_ff @(posedge clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_id_ex.valid <= 1'b0;
    end else begin
      o_id_ex.valid <= i_if_valid && !i_flush;
    end
  end

  always_ff @(posedge clock) begin
    o_id_ex.pc        <= i_if_pc;
    o_id_ex.rs1_data  <= bypass(i_fwd_rs1, (rs1 == '0) ? '0 : regs[rs1]);
    o_id_ex.rs2_data  <= bypass(i_fwd_rs2, (rs2 == '0) ? '0 : regs[rs2]);
    o_id_ex.imm       <= imm;
    o_id_ex.rd        <= i_if_instr[11:7];
    o_id_ex.reg_write <= i_reg_write;
    o_id_ex.alu_op    <= i_alu_op;
    o_id_ex.opa_sel   <= i_opa_sel;
    o_id_ex.opb_imm   <= i_opb_imm;
    o_id_ex.next_pc   <= i_next_pc;
    o_id_ex.funct3    <= i_if_instr[14:12];
  end

endmodule

`default_nettype wire

// File: src/execute_unit.sv
/*
 * Execute stage
 * ALU, branch resolution, jump targets and the EX/WB register
 */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input  logic                           clock,
  input  logic                           i_rst_n,
  id_ex_if.execute                       i_id_ex,
  output logic [core_pkg::XLEN-1:0]      o_ex_result,
  output logic [core_pkg::REG_BITS-1:0]  o_ex_rd,
  output logic                           o_ex_reg_write,
  output logic                           o_redirect,
  output logic [core_pkg::ADDR_BITS-1:0] o_redirect_target,
  output logic                           o_wb_valid,
  output logic [core_pkg::REG_BITS-1:0]  o_wb_rd,
  output logic [core_pkg::XLEN-1:0]      o_wb_data
);

  logic [core_pkg::XLEN-1:0] pc_ext;
  logic [core_pkg::XLEN-1:0] op_a;
  logic [core_pkg::XLEN-1:0] op_b;
  logic [core_pkg::XLEN-1:0] alu_result;
  logic                      taken;
  logic                      is_jump;

  assign pc_ext = {{(core_pkg::XLEN - core_pkg::ADDR_BITS){1'b0}}, i_id_ex.pc};
  assign op_a   = (i_id_ex.opa_sel == core_pkg::OPA_PC) ? pc_ext : i_id_ex.rs1_data;
  assign op_b   = i_id_ex.opb_imm ? i_id_ex.imm : i_id_ex.rs2_data;

  always_comb begin
    case (i_id_ex.alu_op)
      core_pkg::ALU_ADD:    alu_result = op_a + op_b;
      core_pkg::ALU_SUB:    alu_result = op_a - op_b;
      core_pkg::ALU_SLL:    alu_result = op_a << op_b[4:0];
      core_pkg::ALU_SLT:    alu_result = ($signed(op_a) < $signed(op_b)) ? 1 : 0;
      core_pkg::ALU_SLTU:   alu_result = (op_a < op_b) ? 1 : 0;
      core_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
      core_pkg::ALU_SRL:    alu_result = op_a >> op_b[4:0];
      core_pkg::ALU_SRA:    alu_result = $signed(op_a) >>> op_b[4:0];
      core_pkg::ALU_OR:     alu_result = op_a | op_b;
      core_pkg::ALU_PASS_B: alu_result = op_b;
      default:              alu_result = op_a & op_b;
    endcase
  end

  always_comb begin
    case (i_id_ex.funct3)
      3'b000:  taken = i_id_ex.rs1_data == i_id_ex.rs2_data;
      3'b001:  taken = i_id_ex.rs1_data != i_id_ex.rs2_data;
      3'b100:  taken = $signed(i_id_ex.rs1_data) < $signed(i_id_ex.rs2_data);
      3'b101:  taken = $signed(i_id_ex.rs1_data) >= $signed(i_id_ex.rs2_data);
      3'b110:  taken = i_id_ex.rs1_data < i_id_ex.rs2_data;
      3'b111:  taken = i_id_ex.rs1_data >= i_id_ex.rs2_data;
      default: taken = 1'b0;
    endcase
  end

  assign is_jump = (i_id_ex.next_pc == core_pkg::NPC_JAL) ||
                   (i_id_ex.next_pc == core_pkg::NPC_JALR);

  // Jumps link the address of the next instruction
  assign o_ex_result    = is_jump ? pc_ext + 4 : alu_result;
  assign o_ex_rd        = i_id_ex.rd;
  assign o_ex_reg_write = i_id_ex.valid && i_id_ex.reg_write;

  assign o_redirect = i_id_ex.valid &&
                      (is_jump || (i_id_ex.next_pc == core_pkg::NPC_BRANCH && taken));

  // JALR adds rs1 and imm in the ALU
  assign o_redirect_target = (i_id_ex.next_pc == core_pkg::NPC_JALR) ?
                             {alu_result[core_pkg::ADDR_BITS-1:1], 1'b0} :
                             i_id_ex.pc + i_id_ex.imm[core_pkg::ADDR_BITS-1:0];

  always_ff @(posedge clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wb_valid <= 1'b0;
    end else begin
      o_wb_valid <= o_ex_reg_write;
    end
  end

  always_ff @(posedge clock) begin
    o_wb_rd   <= o_ex_rd;
    o_wb_data <= o_ex_result;
  end

endmodule

`default_nettype wire

// File: src/writeback_unit.sv
/*
 * Writeback stage
 * Register file write port and the peripheral report for a0..a7
 */
`timescale 1ns/1ps
`default_nettype none

module writeback_unit (
  input  logic                          clock,
  input  logic                          i_rst_n,
  input  logic                          i_wb_valid,
  input  logic [core_pkg::REG_BITS-1:0] i_wb_rd,
  input  logic [core_pkg::XLEN-1:0]     i_wb_data,
  output logic                          o_reg_write,
  output logic [core_pkg::REG_BITS-1:0] o_reg_rd,
  output logic [core_pkg::XLEN-1:0]     o_reg_data,
  output logic                          o_periph_valid,
  output logic [core_pkg::XLEN-1:0]     o_periph_data
);

  logic periph_hit;

  // x0 stays zero
  assign o_reg_write = i_wb_valid && (i_wb_rd != '0);
  assign o_reg_rd    = i_wb_rd;
  assign o_reg_data  = i_wb_data;

  assign periph_hit = o_reg_write && (i_wb_rd >= core_pkg::PERIPH_REG_FIRST) &&
                      (i_wb_rd <= core_pkg::PERIPH_REG_LAST);

  always_ff @(posedge clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_periph_valid <= 1'b0;
    end else begin
      o_periph_valid <= periph_hit;
    end
  end

  always_ff @(posedge clock) begin
    if (periph_hit) begin
      o_periph_data <= i_wb_data;
    end
  end

  periph_in_range: assert property (@(posedge clock) disable iff (!i_rst_n)
    o_periph_valid |-> $past(o_reg_write) &&
                       $past(i_wb_rd) >= core_pkg::PERIPH_REG_FIRST &&
                       $past(i_wb_rd) <= core_pkg::PERIPH_REG_LAST);

endmodule

`default_nettype wire

// File: src/riscv_core.sv
/*
 * RV32I core top level
 * Four-stage pipeline with ISP-loaded instruction memory
 */
`timescale 1ns/1ps
`default_nettype none

module riscv_core (
  input  logic                           clock,
  input  logic                           i_rst_n,
  input  logic                           i_start,
  input  logic [core_pkg::ADDR_BITS-1:0] i_prog_address,
  input  logic                           i_isp_write,
  input  logic [core_pkg::ADDR_BITS-1:0] i_isp_address,
  input  logic [core_pkg::XLEN-1:0]      i_isp_data,
  output logic [core_pkg::ADDR_BITS-1:0] o_current_pc,
  output logic                           o_periph_valid,
  output logic [core_pkg::XLEN-1:0]      o_periph_data
);

  logic [core_pkg::ADDR_BITS-1:0] fetch_address;
  logic [core_pkg::XLEN-1:0]      fetch_data;
  logic                           if_valid;
  logic [core_pkg::XLEN-1:0]      if_instr;
  logic                           redirect;
  logic [core_pkg::ADDR_BITS-1:0] redirect_target;
  core_pkg::alu_op_e              alu_op;
  core_pkg::opa_sel_e             opa_sel;
  logic                           opb_imm;
  core_pkg::next_pc_e             next_pc;
  logic                           dec_reg_write;
  core_pkg::fwd_sel_e             fwd_rs1;
  core_pkg::fwd_sel_e             fwd_rs2;
  logic                           flush;
  logic [core_pkg::XLEN-1:0]      ex_result;
  logic [core_pkg::REG_BITS-1:0]  ex_rd;
  logic                           ex_reg_write;
  logic                           wb_valid;
  logic [core_pkg::REG_BITS-1:0]  wb_rd;
  logic [core_pkg::XLEN-1:0]      wb_data;
  logic                           reg_write;
  logic [core_pkg::REG_BITS-1:0]  reg_rd;
  logic [core_pkg::XLEN-1:0]      reg_data;

  id_ex_if id_ex ();

  instr_mem u_instr_mem (
    .clock, .i_isp_write, .i_isp_address, .i_isp_data,
    .i_fetch_address (fetch_address),
    .o_fetch_data    (fetch_data)
  );

  // IF/ID program counter doubles as the current PC
  fetch_unit u_fetch (
    .clock, .i_rst_n, .i_start, .i_prog_address,
    .i_redirect        (redirect),
    .i_redirect_target (redirect_target),
    .o_fetch_address   (fetch_address),
    .i_fetch_data      (fetch_data),
    .o_if_valid        (if_valid),
    .o_if_instr        (if_instr),
    .o_if_pc           (o_current_pc)
  );

  control_unit u_control (
    .clock,
    .i_if_valid     (if_valid),
    .i_instr        (if_instr),
    .i_ex_rd        (ex_rd),
    .i_ex_reg_write (ex_reg_write),
    .i_wb_rd        (reg_rd),
    .i_wb_write     (reg_write),
    .i_redirect     (redirect),
    .o_alu_op       (alu_op),
    .o_opa_sel      (opa_sel),
    .o_opb_imm      (opb_imm),
    .o_next_pc      (next_pc),
    .o_reg_write    (dec_reg_write),
    .o_fwd_rs1      (fwd_rs1),
    .o_fwd_rs2      (fwd_rs2),
    .o_flush        (flush)
  );

  decode_unit u_decode (
    .clock, .i_rst_n,
    .i_if_valid  (if_valid),
    .i_if_instr  (if_instr),
    .i_if_pc     (o_current_pc),
    .i_alu_op    (alu_op),
    .i_opa_sel   (opa_sel),
    .i_opb_imm   (opb_imm),
    .i_next_pc   (next_pc),
    .i_reg_write (dec_reg_write),
    .i_fwd_rs1   (fwd_rs1),
    .i_fwd_rs2   (fwd_rs2),
    .i_flush     (flush),
    .i_ex_result (ex_result),
    .i_wb_write  (reg_write),
    .i_wb_rd     (reg_rd),
    .i_wb_data   (reg_data),
    .o_id_ex     (id_ex.decode)
  );

  execute_unit u_execute (
    .clock, .i_rst_n,
    .i_id_ex           (id_ex.execute),
    .o_ex_result       (ex_result),
    .o_ex_rd           (ex_rd),
    .o_ex_reg_write    (ex_reg_write),
    .o_redirect        (redirect),
    .o_redirect_target (redirect_target),
    .o_wb_valid        (wb_valid),
    .o_wb_rd           (wb_rd),
    .o_wb_data         (wb_data)
  );

  writeback_unit u_writeback (
    .clock, .i_rst_n,
    .i_wb_valid     (wb_valid),
    .i_wb_rd        (wb_rd),
    .i_wb_data      (wb_data),
    .o_reg_write    (reg_write),
    .o_reg_rd       (reg_rd),
    .o_reg_data     (reg_data),
    .o_periph_valid,
    .o_periph_data
  );

endmodule

`default_nettype wire

// File: dv/tb_programs.svh
/*
 * Test programs for the RV32I core testbench
 * Instruction encoders and the table of programs with expected a0..a7 reports
 */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH
`default_nettype none

localparam logic [6:0] OPC_R = 7'b0110011;
localparam logic [6:0] OPC_I = 7'b0010011;
localparam logic [4:0] T0 = 5, T1 = 6, T2 = 7, S1 = 9, S2 = 18;
localparam logic [4:0] A0 = 10, A1 = 11, A2 = 12, A3 = 13;
localparam logic [4:0] A4 = 14, A5 = 15, A6 = 16, A7 = 17;

function automatic logic [31:0] r_op(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, OPC_R};
endfunction

function automatic logic [31:0] i_op(input int imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] opc);
  logic [31:0] v;
  v = imm;
  return {v[11:0], rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] u_op(input logic [19:0] imm20, input logic [4:0] rd,
                                     input logic [6:0] opc);
  return {imm20, rd, opc};
endfunction

function automatic logic [31:0] b_op(input int off, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
  logic [31:0] v;
  v = off;
  return {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], 7'b1100011};
endfunction

function automatic logic [31:0] j_op(input int off, input logic [4:0] rd);
  logic [31:0] v;
  v = off;
  return {v[20], v[10:1], v[11], v[19:12], rd, 7'b1101111};
endfunction

// Every program parks on a jump to itself
task automatic build_table();
  logic [2:0] f3_list [6];
  logic [4:0] tk_a [6];
  logic [4:0] tk_b [6];
  logic [4:0] nt_a [6];
  logic [4:0] nt_b [6];
  f3_list = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
  // t0 = 5, t1 = -3, t2 = 5
  tk_a = '{T0, T0, T1, T0, T0, T1};
  tk_b = '{T2, T1, T0, T1, T1, T0};
  nt_a = '{T0, T0, T0, T1, T1, T0};
  nt_b = '{T1, T2, T1, T0, T0, T1};

  begin_test("alu_ops");
  emit(i_op(12, 0, 3'b000, T0, OPC_I));
  emit(i_op(-7, 0, 3'b000, T1, OPC_I));
  emit(i_op(100, 0, 3'b000, A0, OPC_I));          expect_value(32'd100);
  emit(r_op(7'h00, T1, T0, 3'b000, A1));          expect_value(32'd5);
  emit(r_op(7'h20, T1, T0, 3'b000, A2));          expect_value(32'd19);
  emit(i_op(255, T0, 3'b100, A3, OPC_I));         expect_value(32'hf3);
  emit(r_op(7'h00, T0, T1, 3'b010, A4));          expect_value(32'd1);
  emit(r_op(7'h00, T0, T1, 3'b011, A5));          expect_value(32'd0);
  emit(i_op(32'h401, T1, 3'b101, A6, OPC_I));     expect_value(32'hfffffffc);
  emit(i_op(28, T1, 3'b101, A7, OPC_I));          expect_value(32'hf);
  emit(r_op(7'h00, T1, T0, 3'b111, A0));          expect_value(32'd8);
  emit(r_op(7'h00, T1, T0, 3'b110, A1));          expect_value(32'hfffffffd);
  emit(i_op(4, T0, 3'b001, A2, OPC_I));           expect_value(32'hc0);
  emit(i_op(15, T1, 3'b111, A3, OPC_I));          expect_value(32'd9);
  emit(i_op(-8, T1, 3'b010, A4, OPC_I));          expect_value(32'd0);
  emit(i_op(13, T0, 3'b011, A5, OPC_I));          expect_value(32'd1);
  emit(i_op(32'h100, T0, 3'b110, A6, OPC_I));     expect_value(32'h10c);
  emit(r_op(7'h00, T1, T0, 3'b100, A7));          expect_value(32'hfffffff5);
  emit(j_op(0, 0));

  begin_test("bypass");
  emit(i_op(1, 0, 3'b000, A0, OPC_I));            expect_value(32'd1);
  emit(i_op(2, A0, 3'b000, A1, OPC_I));           expect_value(32'd3);
  emit(r_op(7'h00, A0, A1, 3'b000, A2));          expect_value(32'd4);
  emit(r_op(7'h00, A2, A2, 3'b000, A3));          expect_value(32'd8);
  emit(i_op(1, A3, 3'b000, T0, OPC_I));
  emit(i_op(0, 0, 3'b000, 0, OPC_I));
  emit(r_op(7'h00, A3, T0, 3'b000, A4));          expect_value(32'd17);
  emit(r_op(7'h20, T0, A4, 3'b000, A5));          expect_value(32'd8);
  emit(i_op(7, 0, 3'b000, A6, OPC_I));            expect_value(32'd7);
  emit(i_op(9, 0, 3'b000, A6, OPC_I));            expect_value(32'd9);
  // Newest a6 must win over the older one
  emit(r_op(7'h00, A6, A6, 3'b000, A7));          expect_value(32'd18);
  emit(j_op(0, 0));

  begin_test("branches");
  emit(i_op(5, 0, 3'b000, T0, OPC_I));
  emit(i_op(-3, 0, 3'b000, T1, OPC_I));
  emit(i_op(5, 0, 3'b000, T2, OPC_I));
  for (int k = 0; k < 6; k++) begin
    emit(b_op(12, tk_b[k], tk_a[k], f3_list[k]));
    emit(i_op(32'h66, 0, 3'b000, A7, OPC_I));
    emit(i_op(32'h67, 0, 3'b000, A7, OPC_I));
    emit(i_op(16 * k + 1, 0, 3'b000, A0, OPC_I)); expect_value(16 * k + 1);
    emit(b_op(12, nt_b[k], nt_a[k], f3_list[k]));
    emit(i_op(16 * k + 2, 0, 3'b000, A1, OPC_I)); expect_value(16 * k + 2);
    emit(i_op(16 * k + 3, 0, 3'b000, A2, OPC_I)); expect_value(16 * k + 3);
  end
  emit(j_op(0, 0));

  begin_test("jumps");
  emit(j_op(12, A0));                             expect_value(32'd4);
  emit(i_op(32'h66, 0, 3'b000, A7, OPC_I));
  emit(i_op(32'h67, 0, 3'b000, A7, OPC_I));
  emit(i_op(28, 0, 3'b000, T0, OPC_I));
  emit(i_op(4, T0, 3'b000, A1, 7'b1100111));      expect_value(32'd20);
  emit(i_op(32'h66, 0, 3'b000, A7, OPC_I));
  emit(i_op(32'h67, 0, 3'b000, A7, OPC_I));
  emit(i_op(32'h68, 0, 3'b000, A7, OPC_I));
  emit(i_op(1, A1, 3'b000, A2, OPC_I));           expect_value(32'd21);
  emit(i_op(49, 0, 3'b000, T1, OPC_I));
  // Odd target has bit 0 dropped
  emit(i_op(0, T1, 3'b000, A3, 7'b1100111));      expect_value(32'd44);
  emit(i_op(32'h66, 0, 3'b000, A7, OPC_I));
  emit(j_op(8, A4));                              expect_value(32'd52);
  emit(i_op(32'h66, 0, 3'b000, A7, OPC_I));
  emit(j_op(0, 0));

  begin_test("upper_and_x0");
  emit(u_op(20'h12345, A0, 7'b0110111));          expect_value(32'h12345000);
  emit(u_op(20'h00001, A1, 7'b0010111));          expect_value(32'h00001004);
  emit(i_op(55, 0, 3'b000, 0, OPC_I));
  emit(r_op(7'h00, 0, 0, 3'b000, A2));            expect_value(32'd0);
  emit(i_op(7, 0, 3'b000, S1, OPC_I));
  emit(i_op(7, 0, 3'b000, S2, OPC_I));
  emit(r_op(7'h00, S2, S1, 3'b000, A3));          expect_value(32'd14);
  emit(u_op(20'hfffff, A4, 7'b0110111));          expect_value(32'hfffff000);
  emit(u_op(20'hfffff, A5, 7'b0010111));          expect_value(32'hfffff020);
  emit(j_op(0, 0));
endtask

`default_nettype wire
`endif

// File: dv/tb_riscv_core.sv
/*
 * Testbench for the RV32I core
 * Loads each table program over ISP, starts it and checks the a0..a7 reports
 */
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_core;

  localparam int NUM_TESTS = 5;
  localparam int MAX_WORDS = 64;
  localparam int MAX_EXP   = 20;
  localparam int QUIET     = 12;

  logic                           clock;
  logic                           i_rst_n;
  logic                           i_start;
  logic [core_pkg::ADDR_BITS-1:0] i_prog_address;
  logic                           i_isp_write;
  logic [core_pkg::ADDR_BITS-1:0] i_isp_address;
  logic [core_pkg::XLEN-1:0]      i_isp_data;
  logic [core_pkg::ADDR_BITS-1:0] o_current_pc;
  logic                           o_periph_valid;
  logic [core_pkg::XLEN-1:0]      o_periph_data;

  string       test_names [NUM_TESTS];
  logic [31:0] prog_words [NUM_TESTS][MAX_WORDS];
  int          prog_len   [NUM_TESTS];
  logic [31:0] exp_vals   [NUM_TESTS][MAX_EXP];
  int          exp_cnt    [NUM_TESTS];
  int          cur        = -1;
  int          test_errors;
  int          passed     = 0;
  int          failed     = 0;
  int          cycles     = 0;
  int          limit      = 0;
  int          seed       = 32'hd125;

  riscv_core i_riscv_core (
    .clock, .i_rst_n, .i_start, .i_prog_address, .i_isp_write,
    .i_isp_address, .i_isp_data, .o_current_pc, .o_periph_valid, .o_periph_data
  );

  always #4 clock = ~clock;

  // Watchdog over the whole run
  always @(posedge clock) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout after %0d cycles, the run did not finish", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic begin_test(input string name);
    cur++;
    test_names[cur] = name;
    prog_len[cur]   = 0;
    exp_cnt[cur]    = 0;
  endtask

  task automatic emit(input logic [31:0] word);
    prog_words[cur][prog_len[cur]] = word;
    prog_len[cur]++;
  endtask

  task automatic expect_value(input logic [31:0] value);
    exp_vals[cur][exp_cnt[cur]] = value;
    exp_cnt[cur]++;
  endtask

  task automatic check_value(input string name, input int idx, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s report %0d: expected %h, actual %h", name, idx, expected, actual);
      test_errors++;
    end
  endtask

  // Nothing may be reported while the core is idle
  task automatic idle_cycle(input string name);
    @(negedge clock);
    if (o_periph_valid !== 1'b0) begin
      $display("%s: peripheral output fired before the program was started", name);
      test_errors++;
    end
  endtask

  task automatic run_test(input int t);
    int                             got;
    int                             quiet;
    int                             n;
    int                             idle;
    int                             budget;
    logic [core_pkg::ADDR_BITS-1:0] park;
    logic                           parked;
    test_errors = 0;
    budget = 4 * prog_len[t] + 32;
    @(negedge clock);
    i_rst_n = 1'b0;
    repeat (3) idle_cycle(test_names[t]);
    i_rst_n = 1'b1;
    for (int w = 0; w < prog_len[t]; w++) begin
      i_isp_write   = 1'b1;
      i_isp_address = w * 4;
      i_isp_data    = prog_words[t][w];
      idle_cycle(test_names[t]);
    end
    i_isp_write = 1'b0;
    idle = $unsigned($random(seed)) % 4;
    repeat (idle + 1) idle_cycle(test_names[t]);
    i_start        = 1'b1;
    i_prog_address = '0;
    @(negedge clock);
    i_start = 1'b0;
    got   = 0;
    quiet = 0;
    n     = 0;
    while (n < budget && !(got >= exp_cnt[t] && quiet >= QUIET)) begin
      if (o_periph_valid) begin
        if (got < exp_cnt[t]) begin
          check_value(test_names[t], got, exp_vals[t][got], o_periph_data);
        end else begin
          $display("%s: unexpected extra report %h", test_names[t], o_periph_data);
          test_errors++;
        end
        got++;
        quiet = 0;
      end else begin
        quiet++;
      end
      @(negedge clock);
      n++;
    end
    if (got < exp_cnt[t]) begin
      $display("%s: only %0d of %0d reports arrived", test_names[t], got, exp_cnt[t]);
      test_errors++;
    end
    // The closing self-jump brings the fetch PC back to the last word every 3 cycles
    park   = 4 * (prog_len[t] - 1);
    parked = 1'b0;
    repeat (3) begin
      if (o_current_pc === park) begin
        parked = 1'b1;
      end
      @(negedge clock);
    end
    if (!parked) begin
      $display("%s: current PC never returned to the final jump at %h", test_names[t], park);
      test_errors++;
    end
    if (test_errors == 0) begin
      $display("PASS %s (%0d reports)", test_names[t], got);
      passed++;
    end else begin
      $display("FAIL %s (%0d errors)", test_names[t], test_errors);
      failed++;
    end
  endtask

  initial begin
    int total;
    clock          = 1'b0;
    i_rst_n        = 1'b0;
    i_start        = 1'b0;
    i_prog_address = '0;
    i_isp_write    = 1'b0;
    i_isp_address  = '0;
    i_isp_data     = '0;
    build_table();
    // Reset, load, idle and run budget for each test
    total = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total += 64 + 5 * prog_len[t] + 48;
    end
    limit = total;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Tests: %0d passed, %0d failed", passed, failed);
    if (failed == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  `include "tb_programs.svh"

endmodule

`default_nettype wire

// File: src.f
src/core_pkg.sv
src/id_ex_if.sv
src/instr_mem.sv
src/fetch_unit.sv
src/control_unit.sv
src/decode_unit.sv
src/execute_unit.sv
src/writeback_unit.sv
src/riscv_core.sv
+incdir+dv
dv/tb_riscv_core.sv
